//--- design/node_type_pkg.sv
package node_type_pkg;

    // width of one node code
    localparam int NODE_W = 4;

    // one-hot node codes, fix marks a correction
    typedef enum logic [NODE_W-1:0] {
        NT_KILL = 4'b0001,
        NT_PASS = 4'b0010,
        NT_HOLD = 4'b0100,
        NT_FIX  = 4'b1000
    } node_type_e;

    // direction of the merge rule
    typedef enum logic {
        SIDE_P = 1'b0,
        SIDE_N = 1'b1
    } merge_side_e;

    // anything not one-hot is treated as kill
    function automatic node_type_e to_node(input logic [NODE_W-1:0] code);
        node_type_e t;
        case (code)
            NT_KILL, NT_PASS, NT_HOLD, NT_FIX: t = node_type_e'(code);
            default: t = NT_KILL;
        endcase
        return t;
    endfunction

    // p side: a left pass hands over to the right input
    // n side: a right pass hands over to the left input
    function automatic node_type_e merge_node(
        input merge_side_e       side,
        input logic [NODE_W-1:0] left,
        input logic [NODE_W-1:0] right
    );
        node_type_e l;
        node_type_e r;
        l = to_node(left);
        r = to_node(right);
        if (side == SIDE_P) begin
            return (l == NT_PASS) ? r : l;
        end
        return (r == NT_PASS) ? l : r;
    endfunction

endpackage

//--- design/tree_layout_pkg.sv
package tree_layout_pkg;

    import node_type_pkg::*;

    // N37 layout: 32 large-tree leaves, 4 small-tree leaves, 1 tail
    localparam int LARGE_LEAVES = 32;
    localparam int SMALL_LEAVES = 4;
    localparam int TAIL_LEAVES  = 1;
    localparam int NODE_COUNT   = LARGE_LEAVES + SMALL_LEAVES + TAIL_LEAVES;

    // full vector width, 148 bits
    localparam int INPUT_W = NODE_COUNT * NODE_W;

    localparam int LARGE_W = LARGE_LEAVES * NODE_W;
    localparam int SMALL_W = SMALL_LEAVES * NODE_W;
    localparam int TAIL_W  = TAIL_LEAVES * NODE_W;

    // large tree in the upper bits, tail in bits 3:0
    // bit 147 down to 20 is the large tree, 19 down to 4 the small tree
    typedef struct packed {
        logic [LARGE_W-1:0] large_tree;
        logic [SMALL_W-1:0] small_tree;
        logic [TAIL_W-1:0]  tail;
    } tree_input_t;

    // every node set to kill
    localparam tree_input_t ALL_KILL = tree_input_t'({NODE_COUNT{NT_KILL}});

endpackage

//--- design/merge_tree.sv
`timescale 1ns/1ps

module merge_tree
    import node_type_pkg::*;
#(
    parameter int          LEAVES = 2,
    parameter merge_side_e SIDE   = SIDE_P
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [LEAVES*NODE_W-1:0] leaves,
    output node_type_e               root
);

    localparam int LEVELS = $clog2(LEAVES);

    // heap order, node 1 is the root
    // node k merges children 2k (left) and 2k+1 (right)
    // leaves occupy LEAVES .. 2*LEAVES-1
    logic [NODE_W-1:0] node [1:2*LEAVES-1];

    if (LEAVES < 2 || (1 << LEVELS) != LEAVES) begin : g_bad_leaves
        $error("merge_tree: LEAVES must be a power of two and at least 2");
    end

    // first heap leaf is the most significant node of the vector
    for (genvar k = 0; k < LEAVES; k++) begin : g_leaf
        assign node[LEAVES + k] = leaves[(LEAVES - k)*NODE_W - 1 -: NODE_W];
    end

    // level 0 pairs the leaves, the last level produces the root
    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int BASE = LEAVES >> (lvl + 1);

        for (genvar n = 0; n < BASE; n++) begin : g_merge
            assign node[BASE + n] = merge_node(SIDE,
                                               node[2*(BASE + n)],
                                               node[2*(BASE + n) + 1]);
        end
    end

    assign root = node_type_e'(node[1]);

    // bad leaf codes must never reach the root
    a_root_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(root)
    ) else $error("merge_tree: root %h is not one-hot", root);

endmodule

//--- design/polarity_tree.sv
`timescale 1ns/1ps

module polarity_tree
    import node_type_pkg::*;
    import tree_layout_pkg::*;
#(
    parameter merge_side_e SIDE = SIDE_P
) (
    input  logic        clk,
    input  logic        rst_n,
    input  tree_input_t nodes,
    output node_type_e  tree_type
);

    node_type_e large_root;
    node_type_e small_root;
    node_type_e small_type;

    // 32 leaves, five levels
    merge_tree #(
        .LEAVES (LARGE_LEAVES),
        .SIDE   (SIDE)
    ) u_large (
        .clk    (clk),
        .rst_n  (rst_n),
        .leaves (nodes.large_tree),
        .root   (large_root)
    );

    // 4 leaves, two levels
    merge_tree #(
        .LEAVES (SMALL_LEAVES),
        .SIDE   (SIDE)
    ) u_small (
        .clk    (clk),
        .rst_n  (rst_n),
        .leaves (nodes.small_tree),
        .root   (small_root)
    );

    // small tree joins the tail first
    assign small_type = merge_node(SIDE, small_root, nodes.tail);

    // then the large tree sits on the left of that result
    assign tree_type = merge_node(SIDE, large_root, small_type);

    // on the p side a decided large root wins over everything below it
    if (SIDE == SIDE_P) begin : g_p_check
        a_large_dominates: assert property (
            @(posedge clk) disable iff (!rst_n)
            !(large_root inside {NT_PASS, NT_KILL}) |-> (tree_type == large_root)
        ) else $error("polarity_tree: large root %h lost to %h", large_root, tree_type);
    end

endmodule

//--- design/correction_tree.sv
`timescale 1ns/1ps

module correction_tree
    import node_type_pkg::*;
    import tree_layout_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  tree_input_t node_input_p,
    input  tree_input_t node_input_n,
    output logic        correct
);

    tree_input_t p_q;
    tree_input_t n_q;
    node_type_e  p_type;
    node_type_e  n_type;
    logic        fix_hit;

    // stage 1, both vectors sampled on every edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p_q <= ALL_KILL;
            n_q <= ALL_KILL;
        end else begin
            p_q <= node_input_p;
            n_q <= node_input_n;
        end
    end

    polarity_tree #(
        .SIDE      (SIDE_P)
    ) u_p_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .nodes     (p_q),
        .tree_type (p_type)
    );

    polarity_tree #(
        .SIDE      (SIDE_N)
    ) u_n_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .nodes     (n_q),
        .tree_type (n_type)
    );

    // either side landing on fix asks for a correction
    assign fix_hit = (p_type == NT_FIX) || (n_type == NT_FIX);

    // stage 2, registered result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            correct <= 1'b0;
        end else begin
            correct <= fix_hit;
        end
    end

    // the pipeline must come out of reset clean
    // the cleared input registers decide correct two edges on
    a_reset_quiet: assert property (
        @(posedge clk)
        !rst_n |-> ##2 !correct
    ) else $error("correction_tree: correct high right after reset");

    a_no_unknown: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(correct)
    ) else $error("correction_tree: correct is unknown");

endmodule

//--- test/tree_model.svh
`ifndef TREE_MODEL_SVH
`define TREE_MODEL_SVH

// reference model of one N37 correction tree pair
// included inside the testbench module, after the package imports

// anything that is not exactly one-hot counts as kill
function automatic logic [NODE_W-1:0] read_code(input logic [NODE_W-1:0] code);
    logic [NODE_W-1:0] result;
    result = $onehot(code) ? code : NT_KILL;
    return result;
endfunction

// a p merge keeps its left input unless that is pass, so the whole
// tree settles on the first non-pass node seen from the top down
function automatic logic [NODE_W-1:0] p_side_result(input logic [INPUT_W-1:0] vec);
    logic [NODE_W-1:0] result;
    logic [NODE_W-1:0] code;
    logic              found;
    result = NT_PASS;
    found  = 1'b0;
    for (int i = NODE_COUNT - 1; i >= 0; i--) begin
        code = read_code(vec[i*NODE_W +: NODE_W]);
        if (!found && code != NT_PASS) begin
            result = code;
            found  = 1'b1;
        end
    end
    return result;
endfunction

// mirror image, first non-pass node seen from the tail upwards
function automatic logic [NODE_W-1:0] n_side_result(input logic [INPUT_W-1:0] vec);
    logic [NODE_W-1:0] result;
    logic [NODE_W-1:0] code;
    logic              found;
    result = NT_PASS;
    found  = 1'b0;
    for (int i = 0; i < NODE_COUNT; i++) begin
        code = read_code(vec[i*NODE_W +: NODE_W]);
        if (!found && code != NT_PASS) begin
            result = code;
            found  = 1'b1;
        end
    end
    return result;
endfunction

function automatic logic expected_correct(
    input logic [INPUT_W-1:0] p_vec,
    input logic [INPUT_W-1:0] n_vec
);
    logic hit;
    hit = (p_side_result(p_vec) == NT_FIX) || (n_side_result(n_vec) == NT_FIX);
    return hit;
endfunction

`endif

//--- test/correction_tree_tb.sv
`timescale 1ns/1ps

module correction_tree_tb
    import node_type_pkg::*;
    import tree_layout_pkg::*;
();

    // reset 4 + four directed tests of at most 10 cycles each
    // + 200 random pairs + drains, about 250 cycles, over twice that for margin
    localparam int TIMEOUT_CYCLES = 600;
    localparam int RANDOM_PAIRS   = 200;

    logic        clk;
    logic        rst_n;
    tree_input_t node_input_p;
    tree_input_t node_input_n;
    logic        correct;

    int          seed        = 64;
    int          errors      = 0;
    int          checks_done = 0;
    int          cycle_count = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    // expected values, two entries deep to match the pipeline
    bit          exp_q [$];
    logic        exp_correct = 1'b0;
    logic        exp_valid   = 1'b0;
    logic [1:0]  rst_hist    = 2'b00;

    `include "tree_model.svh"

    correction_tree uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .node_input_p (node_input_p),
        .node_input_n (node_input_n),
        .correct      (correct)
    );

    initial clk = 1'b0;

    always #50 clk = ~clk;

    // push the model result for the pair sampled at this edge
    always @(posedge clk) begin
        exp_q.push_back(rst_n ? expected_correct(node_input_p, node_input_n) : 1'b0);
        if (exp_q.size() > 2) begin
            void'(exp_q.pop_front());
        end
        exp_correct <= exp_q[0];
        exp_valid   <= (exp_q.size() == 2);
        rst_hist    <= {rst_hist[0], rst_n};
        if (exp_valid) begin
            checks_done <= checks_done + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, tests did not finish", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    a_correct_matches: assert property (
        @(posedge clk) exp_valid |-> (correct === exp_correct)
    ) else begin
        errors++;
        $display("Mismatch correct: got %h expected %h at cycle %0d",
                 $sampled(correct), $sampled(exp_correct), cycle_count);
    end

    // reset cycles and the cycle right after them
    a_reset_low: assert property (
        @(posedge clk) (cycle_count > 0 && rst_hist != 2'b11) |-> (correct === 1'b0)
    ) else begin
        errors++;
        $display("Mismatch correct: got %h expected 0 around reset", $sampled(correct));
    end

    function automatic tree_input_t fill_nodes(input logic [NODE_W-1:0] code);
        logic [INPUT_W-1:0] flat;
        flat = {NODE_COUNT{code}};
        return tree_input_t'(flat);
    endfunction

    // node 0 is the tail, node 36 the most significant large leaf
    function automatic tree_input_t set_node(
        input tree_input_t       vec,
        input int                idx,
        input logic [NODE_W-1:0] code
    );
        logic [INPUT_W-1:0] flat;
        flat = vec;
        flat[idx*NODE_W +: NODE_W] = code;
        return tree_input_t'(flat);
    endfunction

    // half pass, the rest kill, hold, fix or a raw nibble
    function automatic logic [NODE_W-1:0] random_node();
        logic [31:0]       r;
        logic [NODE_W-1:0] code;
        r = $random(seed);
        case (r[2:0])
            3'd4:    code = NT_KILL;
            3'd5:    code = NT_HOLD;
            3'd6:    code = NT_FIX;
            3'd7:    code = r[11:8];
            default: code = NT_PASS;
        endcase
        return code;
    endfunction

    function automatic tree_input_t random_tree();
        tree_input_t vec;
        vec = fill_nodes(NT_PASS);
        for (int i = 0; i < NODE_COUNT; i++) begin
            vec = set_node(vec, i, random_node());
        end
        return vec;
    endfunction

    task automatic apply_pair(input tree_input_t p, input tree_input_t n);
        @(posedge clk);
        #1;
        node_input_p = p;
        node_input_n = n;
    endtask

    // all-kill pairs until the last real pair has been compared
    task automatic drain_pipeline();
        repeat (3) begin
            apply_pair(ALL_KILL, ALL_KILL);
        end
    endtask

    task automatic expect_value(
        input string             name,
        input logic [NODE_W-1:0] got,
        input logic [NODE_W-1:0] want
    );
        assert (got === want) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %0d checks, %0d errors",
                 name, checks_done - test_checks, errors - test_errors);
        test_checks = checks_done;
        test_errors = errors;
    endtask

    initial begin
        tree_input_t p;
        tree_input_t n;
        tree_input_t v;

        // a pattern that would raise correct if reset let it through
        rst_n        = 1'b0;
        node_input_p = set_node(fill_nodes(NT_PASS), 0, NT_FIX);
        node_input_n = fill_nodes(NT_PASS);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        drain_pipeline();
        end_test("reset");

        // fix in the p tail travels through an all-pass tree
        p = set_node(fill_nodes(NT_PASS), 0, NT_FIX);
        n = fill_nodes(NT_PASS);
        expect_value("p_side_result", p_side_result(p), NT_FIX);
        expect_value("n_side_result", n_side_result(n), NT_PASS);
        expect_value("expected_correct", {3'b000, expected_correct(p, n)}, 4'h1);
        apply_pair(p, n);
        drain_pipeline();
        end_test("tail");

        // p reads from the top, n from the tail
        p = set_node(set_node(fill_nodes(NT_PASS), 36, NT_FIX), 0, NT_HOLD);
        n = set_node(set_node(fill_nodes(NT_PASS), 36, NT_HOLD), 0, NT_FIX);
        expect_value("p_side_result", p_side_result(p), NT_FIX);
        expect_value("n_side_result", n_side_result(n), NT_FIX);
        apply_pair(p, n);
        apply_pair(p, ALL_KILL);
        apply_pair(ALL_KILL, n);
        v = set_node(fill_nodes(NT_HOLD), 0, NT_FIX);
        expect_value("p_side_result", p_side_result(v), NT_HOLD);
        expect_value("n_side_result", n_side_result(v), NT_FIX);
        apply_pair(v, ALL_KILL);
        apply_pair(ALL_KILL, v);
        drain_pipeline();
        end_test("direction");

        // non-one-hot leaves block a fix further along
        p = set_node(set_node(fill_nodes(NT_PASS), 20, 4'h0), 10, NT_FIX);
        expect_value("p_side_result", p_side_result(p), NT_KILL);
        apply_pair(p, ALL_KILL);
        apply_pair(set_node(p, 20, NT_PASS), ALL_KILL);
        p = set_node(set_node(fill_nodes(NT_PASS), 30, 4'h6), 0, NT_FIX);
        apply_pair(p, ALL_KILL);
        n = set_node(set_node(fill_nodes(NT_PASS), 5, 4'hf), 30, NT_FIX);
        expect_value("n_side_result", n_side_result(n), NT_KILL);
        apply_pair(ALL_KILL, n);
        apply_pair(fill_nodes(4'h0), fill_nodes(4'h0));
        drain_pipeline();
        end_test("bad_code");

        // back to back, two pairs in flight at once
        repeat (RANDOM_PAIRS) begin
            apply_pair(random_tree(), random_tree());
        end
        drain_pipeline();
        end_test("random");

        $display("summary: %0d checks, %0d errors", checks_done, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- correction_tree.f
+incdir+test
design/node_type_pkg.sv
design/tree_layout_pkg.sv
design/merge_tree.sv
design/polarity_tree.sv
design/correction_tree.sv
test/correction_tree_tb.sv

//--- Bender.yml
package:
  name: correction_tree

sources:
  # packages first, then the tree from the leaves up
  - files:
      - design/node_type_pkg.sv
      - design/tree_layout_pkg.sv
      - design/merge_tree.sv
      - design/polarity_tree.sv
      - design/correction_tree.sv

  # testbench with its model header
  - target: test
    include_dirs:
      - test
    files:
      - test/correction_tree_tb.sv
